// ==== Bender.yml ====
package:
  name: aes_wb_core

sources:
  - aes_pkg.sv
  - aes_round_if.sv
  - aes_add_round_key.sv
  - aes_round_datapath.sv
  - aes_key_expand.sv
  - aes_round_counter.sv
  - aes_control_fsm.sv
  - aes_top.sv
  - target: test
    files:
      - tb_aes_top.sv

// ==== aes_add_round_key.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_add_round_key (
    input  aes_pkg::aes_state_t p,                  // Row-ordered state
    input  aes_pkg::aes_key_t   k,                  // Row-ordered round key
    output aes_pkg::aes_state_t o                   // Column-ordered result
);

    always_comb
    begin
        for (int i = 0; i < 16; i++)
        begin
            o[4 * (i % 4) + i / 4] = p[i] ^ k[8 * i +: 8];   // Row r col c lands at 4c+r
        end
    end

endmodule

`default_nettype wire

// ==== aes_control_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_control_fsm (
    input  logic                clk,
    input  logic                resetn,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  logic [3:0]          adr,
    input  logic [31:0]         dat_i,
    output logic [31:0]         dat_o,
    output logic                ack,
    input  aes_pkg::aes_state_t state,              // Cipher state from the datapath
    output aes_pkg::aes_key_t   key,                // Staged key
    output aes_pkg::aes_state_t text,               // Staged plaintext
    aes_round_if.ctrl           rnd
);
    import aes_pkg::*;

    aes_run_e    run_q;
    aes_run_e    run_n;
    aes_reg_e    reg_sel;
    logic        wr_en;
    logic        start;
    logic [31:0] rd_word;

    // Word n holds bytes 4n to 4n+3 with the lowest byte in the top bits
    function automatic logic [31:0] get_word(aes_state_t s, logic [1:0] n);
        return {s[4 * n], s[4 * n + 1], s[4 * n + 2], s[4 * n + 3]};
    endfunction

    function automatic aes_state_t put_word(aes_state_t s, logic [1:0] n, logic [31:0] w);
        aes_state_t r;
        r = s;
        for (int b = 0; b < 4; b++)
        begin
            r[4 * n + b] = w[8 * (3 - b) +: 8];
        end
        return r;
    endfunction

    assign reg_sel = aes_reg_e'(adr);
    assign wr_en   = cyc && stb && we && ack;       // Writes land on the ack cycle
    assign start   = wr_en && (reg_sel == CTRL) && dat_i[0];

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            ack <= 1'b0;
        end
        else
        begin
            ack <= cyc && stb && !ack;              // Ack rises one clock after a request
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            case (reg_sel)
                KEY0, KEY1, KEY2, KEY3:     key  <= put_word(key, adr[1:0], dat_i);
                TEXT0, TEXT1, TEXT2, TEXT3: text <= put_word(text, adr[1:0], dat_i);
                default: ;                          // CTRL handled by the FSM
            endcase
        end
    end

    always_comb
    begin
        case (reg_sel)
            KEY0, KEY1, KEY2, KEY3:             rd_word = get_word(key, adr[1:0]);
            TEXT0, TEXT1, TEXT2, TEXT3:         rd_word = get_word(text, adr[1:0]);
            STATUS:                             rd_word = {30'd0, run_q == DONE,
                                                           run_q inside {LOAD, RUN}};
            RESULT0, RESULT1, RESULT2, RESULT3: rd_word = get_word(state, adr[1:0] + 2'd2);
            default:                            rd_word = 32'd0;
        endcase
    end

    assign dat_o = ack ? rd_word : 32'd0;

    always_comb
    begin
        run_n = run_q;
        case (run_q)
            IDLE, DONE: if (start) run_n = LOAD;    // Starts while busy are dropped
            LOAD:       run_n = RUN;
            RUN:        if (rnd.last) run_n = DONE; // Round 10 is stepped this cycle
            default:    run_n = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            run_q <= IDLE;
        end
        else
        begin
            run_q <= run_n;
        end
    end

    assign rnd.load = (run_q == LOAD);
    assign rnd.step = (run_q == RUN);

    // Ten stepped rounds after the load and then the result rests in DONE
    a_run_length: assert property (@(posedge clk) disable iff (!resetn)
        rnd.load |-> ##11 (run_q == DONE));

endmodule

`default_nettype wire

// ==== aes_key_expand.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_key_expand (
    input  logic              clk,
    input  logic              resetn,
    input  aes_pkg::aes_key_t key,                  // Cipher key from the staging registers
    aes_round_if.key          rnd
);
    import aes_pkg::*;

    aes_key_t    key_q;                             // Key of the round just finished
    aes_key_t    key_n;                             // Key of the next round
    logic [31:0] sub_w;                             // RotWord and SubWord of the last word
    aes_byte_t   rcon;

    always_comb
    begin
        if (rnd.round inside {[4'd1 : AES_ROUNDS]})
        begin
            rcon = AES_RCON[rnd.round - 4'd1];
        end
        else
        begin
            rcon = 8'h00;
        end

        for (int r = 0; r < 4; r++)
        begin
            sub_w[8 * r +: 8] = AES_SBOX[key_q[96 + 8 * ((r + 1) % 4) +: 8]];  // Rotate by one byte
        end

        key_n[31:0] = key_q[31:0] ^ sub_w ^ {24'h0, rcon};   // Rcon only hits the first byte
        for (int c = 1; c < 4; c++)
        begin
            key_n[32 * c +: 32] = key_q[32 * c +: 32] ^ key_n[32 * (c - 1) +: 32];  // XOR chain
        end
    end

    assign rnd.round_key = rnd.load ? key : key_n;  // Same value the register takes

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            key_q <= '0;
        end
        else if (rnd.load || rnd.step)
        begin
            key_q <= rnd.round_key;
        end
    end

endmodule

`default_nettype wire

// ==== aes_pkg.sv ====
`default_nettype none

package aes_pkg;

    typedef logic [7:0] aes_byte_t;                 // One state byte
    typedef aes_byte_t [15:0] aes_state_t;          // Byte i at bits 8i+7 down to 8i
    typedef logic [127:0] aes_key_t;                // Round key, same byte placement

    localparam logic [3:0] AES_ROUNDS = 4'd10;      // Last round number for AES-128

    // Forward S-box, indexed by the input byte
    localparam aes_byte_t AES_SBOX [0:255] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    // Round constants for rounds 1 to 10
    localparam aes_byte_t AES_RCON [0:9] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    typedef enum logic [1:0] {
        IDLE,                                       // Waiting for a start
        LOAD,                                       // Initial key addition
        RUN,                                        // One cipher round per clock
        DONE                                        // Result stable
    } aes_run_e;

    typedef enum logic [3:0] {
        KEY0    = 4'd0,
        KEY1    = 4'd1,
        KEY2    = 4'd2,
        KEY3    = 4'd3,
        TEXT0   = 4'd4,
        TEXT1   = 4'd5,
        TEXT2   = 4'd6,
        TEXT3   = 4'd7,
        CTRL    = 4'd8,                             // Bit 0 starts a run
        STATUS  = 4'd9,                             // Bit 0 busy, bit 1 done
        RESULT0 = 4'd10,
        RESULT1 = 4'd11,
        RESULT2 = 4'd12,
        RESULT3 = 4'd13
    } aes_reg_e;

endpackage

`default_nettype wire

// ==== aes_round_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_round_counter (
    input  logic      clk,
    input  logic      resetn,
    aes_round_if.ctrl rnd
);
    import aes_pkg::*;

    assign rnd.last = (rnd.round == AES_ROUNDS);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            rnd.round <= 4'd0;
        end
        else if (rnd.load)
        begin
            rnd.round <= 4'd1;                      // First cipher round follows the load
        end
        else if (rnd.step)
        begin
            rnd.round <= rnd.last ? 4'd0 : rnd.round + 4'd1;  // Back to 0 once round 10 is done
        end
    end

    // Once counting starts the controller steps every cycle up to round 10
    a_round_stepped: assert property (@(posedge clk) disable iff (!resetn)
        rnd.round != 4'd0 |-> rnd.step);

    // The controller only steps after a load has set the count
    a_no_step_round0: assert property (@(posedge clk) disable iff (!resetn)
        rnd.step |-> rnd.round != 4'd0);

endmodule

`default_nettype wire

// ==== aes_round_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_round_datapath (
    input  logic                clk,
    input  logic                resetn,
    aes_round_if.data           rnd,
    input  aes_pkg::aes_state_t text,               // Staged plaintext, column order
    output aes_pkg::aes_state_t state               // Cipher state register, column order
);
    import aes_pkg::*;

    aes_byte_t  shift_b [4][4];                     // [row][col] after SubBytes and ShiftRows
    aes_byte_t  mix_b   [4][4];                     // [row][col] after MixColumns
    aes_state_t row_st;                             // Round result in row order
    aes_key_t   key_row;                            // Round key transposed to row order
    aes_state_t ark_o;

    // Multiply by x in GF(2^8)
    function automatic aes_byte_t xtime(aes_byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    always_comb
    begin
        for (int r = 0; r < 4; r++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                shift_b[r][c] = AES_SBOX[state[4 * ((c + r) % 4) + r]];  // Row r rotates left by r
            end
        end
    end

    always_comb
    begin
        for (int r = 0; r < 4; r++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                mix_b[r][c] = xtime(shift_b[r][c])
                            ^ xtime(shift_b[(r + 1) % 4][c]) ^ shift_b[(r + 1) % 4][c]
                            ^ shift_b[(r + 2) % 4][c]
                            ^ shift_b[(r + 3) % 4][c];                // 2a ^ 3b ^ c ^ d
                row_st[4 * r + c] = rnd.last ? shift_b[r][c] : mix_b[r][c];  // No mix in round 10
                key_row[8 * (4 * r + c) +: 8] = rnd.round_key[8 * (4 * c + r) +: 8];
            end
        end
    end

    aes_add_round_key u_ark (
        .p (row_st),
        .k (key_row),
        .o (ark_o)
    );

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state <= '0;
        end
        else if (rnd.load)
        begin
            state <= text ^ rnd.round_key;          // Round 0, both already column order
        end
        else if (rnd.step)
        begin
            state <= ark_o;
        end
    end

endmodule

`default_nettype wire

// ==== aes_round_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface aes_round_if;
    import aes_pkg::*;

    logic       load;                               // Load text and key this cycle
    logic       step;                               // Run one cipher round this cycle
    logic       last;                               // Current round is the final one
    logic [3:0] round;                              // Round number, 0 when idle
    aes_key_t   round_key;                          // Key for this cycle's register update

    // Controller owns load and step, the counter owns round and last
    modport ctrl (output load, output step, output round, output last);
    modport key  (input load, input step, input round, output round_key);
    modport data (input load, input step, input last, input round_key);

endinterface

`default_nettype wire

// ==== aes_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_top (
    input  logic        clk,
    input  logic        resetn,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [3:0]  adr,                        // Word address
    input  logic [31:0] dat_i,
    output logic [31:0] dat_o,
    output logic        ack
);
    import aes_pkg::*;

    aes_key_t   key;                                // Staged key to the expander
    aes_state_t text;                               // Staged plaintext to the datapath
    aes_state_t state;                              // Cipher state back to the bus

    aes_round_if rnd ();

    aes_control_fsm u_ctrl (
        .clk    (clk),
        .resetn (resetn),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_i  (dat_i),
        .dat_o  (dat_o),
        .ack    (ack),
        .state  (state),
        .key    (key),
        .text   (text),
        .rnd    (rnd.ctrl)
    );

    aes_round_counter u_cnt (
        .clk    (clk),
        .resetn (resetn),
        .rnd    (rnd.ctrl)
    );

    aes_key_expand u_key (
        .clk    (clk),
        .resetn (resetn),
        .key    (key),
        .rnd    (rnd.key)
    );

    aes_round_datapath u_dp (
        .clk    (clk),
        .resetn (resetn),
        .rnd    (rnd.data),
        .text   (text),
        .state  (state)
    );

endmodule

`default_nettype wire

// ==== all.f ====
aes_pkg.sv
aes_round_if.sv
aes_add_round_key.sv
aes_round_datapath.sv
aes_key_expand.sv
aes_round_counter.sv
aes_control_fsm.sv
aes_top.sv
tb_aes_top.sv

// ==== tb_aes_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_aes_top;
    import aes_pkg::*;

    logic        clk;
    logic        resetn;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] dat_i;
    logic [31:0] dat_o;
    logic        ack;

    logic [31:0] lfsr_q;                            // Random source state
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          test_err0;                         // Error count when the test began

    aes_top UUT (
        .clk    (clk),
        .resetn (resetn),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_i  (dat_i),
        .dat_o  (dat_o),
        .ack    (ack)
    );

    always #20 clk = ~clk;                          // 40 ns period

    // Galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic random_word(output logic [31:0] w);
        for (int b = 0; b < 32; b++)
        begin
            w[b] = lfsr_q[0];                       // One step per bit taken
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // FIPS hex string to state with the first byte of the string as byte 0
    function automatic aes_state_t to_state(logic [127:0] v);
        aes_state_t s;
        for (int i = 0; i < 16; i++)
        begin
            s[i] = v[127 - 8 * i -: 8];
        end
        return s;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_state(input string name, input aes_state_t got, input aes_state_t exp);
        if (got !== exp)
        begin
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic wb_write(input logic [3:0] a, input logic [31:0] d);
        int n;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        dat_i = d;
        n = 0;
        while (!ack && n < 8)
        begin
            @(negedge clk);
            n++;
        end
        if (!ack)
        begin
            $display("Write to address %0d was never acknowledged within 8 cycles", a);
            errors++;
        end
        else if (n != 1)
        begin
            $display("Write to address %0d was acknowledged after %0d cycles", a, n);
            errors++;
        end
        @(negedge clk);                             // Hold over the ack cycle so the write lands
        if (ack)
        begin
            $display("Ack of the write to address %0d lasted more than one cycle", a);
            errors++;
        end
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_read(input logic [3:0] a, output logic [31:0] d);
        int n;
        @(negedge clk);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        n = 0;
        while (!ack && n < 8)
        begin
            @(negedge clk);
            n++;
        end
        if (ack)
        begin
            d = dat_o;                              // Valid while ack is high
            if (n != 1)
            begin
                $display("Read of address %0d was acknowledged after %0d cycles", a, n);
                errors++;
            end
        end
        else
        begin
            d = 32'd0;
            $display("Read of address %0d was never acknowledged within 8 cycles", a);
            errors++;
        end
        @(negedge clk);
        if (ack)
        begin
            $display("Ack of the read of address %0d lasted more than one cycle", a);
            errors++;
        end
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    // Word n carries bytes 4n..4n+3 with the first byte in the top bits
    task automatic write_block(input logic [3:0] base, input logic [127:0] v);
        for (int n = 0; n < 4; n++)
        begin
            wb_write(base + n[3:0], v[127 - 32 * n -: 32]);
        end
    endtask

    task automatic read_result(output aes_state_t s);
        logic [31:0] w;
        for (int n = 0; n < 4; n++)
        begin
            wb_read(RESULT0 + n[3:0], w);
            for (int b = 0; b < 4; b++)
            begin
                s[4 * n + b] = w[31 - 8 * b -: 8];
            end
        end
    endtask

    task automatic start_run();
        wb_write(CTRL, 32'h1);
    endtask

    task automatic wait_done();
        logic [31:0] w;
        int          polls;
        w     = 32'd0;
        polls = 0;
        while (!w[1] && polls < 40)
        begin
            wb_read(STATUS, w);
            polls++;
        end
        if (!w[1])
        begin
            $display("Done bit was not set within 40 status polls");
            errors++;
        end
        else
        begin
            check_word("STATUS", w, 32'h2);         // Done without busy
        end
    endtask

    task automatic encrypt_check(input logic [127:0] k, input logic [127:0] t,
                                 input logic [127:0] exp);
        aes_state_t got;
        write_block(KEY0, k);
        write_block(TEXT0, t);
        start_run();
        wait_done();
        read_result(got);
        check_state("RESULT", got, to_state(exp));
    endtask

    task automatic begin_test();
        test_err0 = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_err0)
        begin
            $display("%s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - test_err0);
        end
    endtask

    task automatic test_reset_values();
        logic [31:0] w;
        begin_test();
        wb_read(STATUS, w);
        check_word("STATUS", w, 32'h0);
        for (int n = 0; n < 4; n++)
        begin
            wb_read(RESULT0 + n[3:0], w);
            check_word($sformatf("RESULT%0d", n), w, 32'h0);  // State register cleared
        end
        end_test("reset values");
    endtask

    task automatic test_fips_c1();
        logic [31:0] w;
        aes_state_t  got;
        begin_test();
        write_block(KEY0, 128'h000102030405060708090a0b0c0d0e0f);
        write_block(TEXT0, 128'h00112233445566778899aabbccddeeff);
        start_run();
        wb_read(STATUS, w);
        check_word("STATUS", w, 32'h1);             // Still inside the run
        wait_done();
        read_result(got);
        check_state("RESULT", got, to_state(128'h69c4e0d86a7b0430d8cdb78070b4c55a));
        end_test("fips-197 c.1");
    endtask

    task automatic test_fips_b();
        begin_test();
        encrypt_check(128'h2b7e151628aed2a6abf7158809cf4f3c,
                      128'h3243f6a8885a308d313198a2e0370734,
                      128'h3925841d02dc09fbdc118597196a0b32);
        end_test("fips-197 appendix b");
    endtask

    task automatic test_reg_readback();
        logic [31:0] words [8];
        logic [31:0] w;
        begin_test();
        for (int n = 0; n < 8; n++)
        begin
            random_word(words[n]);
            wb_write(n[3:0], words[n]);             // KEY0..KEY3 then TEXT0..TEXT3
        end
        for (int n = 0; n < 8; n++)
        begin
            wb_read(n[3:0], w);
            check_word($sformatf("reg%0d", n), w, words[n]);
        end
        end_test("key and text readback");
    endtask

    task automatic test_start_while_busy();
        logic [31:0] w;
        aes_state_t  got;
        begin_test();
        write_block(KEY0, 128'h2b7e151628aed2a6abf7158809cf4f3c);
        write_block(TEXT0, 128'h3243f6a8885a308d313198a2e0370734);
        start_run();
        start_run();                                // Lands during RUN and is dropped
        wb_read(STATUS, w);
        check_word("STATUS", w, 32'h1);
        wb_read(STATUS, w);
        check_word("STATUS", w, 32'h1);
        wb_read(STATUS, w);
        check_word("STATUS", w, 32'h2);             // Done 12 cycles after the first start
        wait_done();
        read_result(got);
        check_state("RESULT", got, to_state(128'h3925841d02dc09fbdc118597196a0b32));
        start_run();                                // Same staged data again
        wb_read(STATUS, w);
        check_word("STATUS", w, 32'h1);             // Start from DONE is taken
        wait_done();
        read_result(got);
        check_state("RESULT", got, to_state(128'h3925841d02dc09fbdc118597196a0b32));
        end_test("start while busy");
    endtask

    task automatic test_back_to_back();
        begin_test();
        encrypt_check(128'h000102030405060708090a0b0c0d0e0f,
                      128'h00112233445566778899aabbccddeeff,
                      128'h69c4e0d86a7b0430d8cdb78070b4c55a);
        encrypt_check(128'h2b7e151628aed2a6abf7158809cf4f3c,
                      128'h3243f6a8885a308d313198a2e0370734,
                      128'h3925841d02dc09fbdc118597196a0b32);
        end_test("back-to-back runs");
    endtask

    initial
    begin
        clk          = 1'b0;
        resetn       = 1'b0;
        cyc          = 1'b0;
        stb          = 1'b0;
        we           = 1'b0;
        adr          = 4'd0;
        dat_i        = 32'd0;
        lfsr_q       = 32'h5a7131ff;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_err0    = 0;
        repeat (2) @(negedge clk);                  // Reset held for two cycles
        resetn = 1'b1;

        test_reset_values();
        test_fips_c1();
        test_fips_b();
        test_reg_readback();
        test_start_while_busy();
        test_back_to_back();

        $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
